//--- src/aa_cfg.svh
// fixed 32-bit buses; the stream beat layout assumes strobe width plus stream address equals one word
`ifndef AA_CFG_SVH
`define AA_CFG_SVH

// ----------------------------------------
// bus widths
// ----------------------------------------
`define AA_DATA_W        32
`define AA_STRB_W        (`AA_DATA_W / 8)
`define AA_LS_ADDR_W     15
// address field in the low bits of the first stream beat
`define AA_SS_ADDR_W     28

// region code lives in address bits 11:8
`define AA_REGION_MBOX   4'h0
`define AA_REGION_REG    4'h1

// mailbox words, indexed by address bits 4:2
`define AA_MBOX_DEPTH    8
`define AA_MBOX_IDX_W    3

// stream sideband
`define AA_TUSER_W       2
`define AA_TUSER_AXIL_WR 2'b01

`endif

//--- src/aa_axil_pkg.sv
// AXI-Lite side types; region decode looks at address bits 11:8 only, upper bits are ignored
`default_nettype none
`include "aa_cfg.svh"

package aa_axil_pkg;

  // local write headed for the stream, kept until both beats are out
  typedef struct packed {
    logic [`AA_LS_ADDR_W-1:0] addr;
    logic [`AA_DATA_W-1:0]    data;
    logic [`AA_STRB_W-1:0]    strb;
  } fwd_wr_t;

  typedef enum logic [1:0] {
    REGION_REG,
    REGION_MBOX,
    REGION_OUT
  } region_t;

  // anything that is not a bridge code belongs to the far side
  function automatic region_t decode_region(input logic [3:0] code);
    region_t r;
    case (code)
      `AA_REGION_REG:  r = REGION_REG;
      `AA_REGION_MBOX: r = REGION_MBOX;
      default:         r = REGION_OUT;
    endcase
    return r;
  endfunction

endpackage

`default_nettype wire

//--- src/aa_axis_pkg.sv
// stream side types; only the two-beat AXI-Lite write format (tuser 01) is described here
`default_nettype none
`include "aa_cfg.svh"

package aa_axis_pkg;

  // remote write after both beats are seen
  typedef struct packed {
    logic [`AA_SS_ADDR_W-1:0] addr;
    logic [`AA_DATA_W-1:0]    data;
    logic [`AA_STRB_W-1:0]    strb;
  } remote_wr_t;

  // beat order of one write
  typedef enum logic {
    PHASE_ADDR,
    PHASE_DATA
  } beat_phase_t;

endpackage

`default_nettype wire

//--- src/hold_slot.sv
// single-entry buffer; in_ready combinationally follows out_ready when full
`timescale 1ns/10ps
`default_nettype none

module hold_slot #(
  parameter type payload_t = logic [31:0]
) (
  input  wire           axis_clk,
  input  wire           axis_rst_n,
  input  wire           in_valid,
  output logic          in_ready,
  input  wire payload_t in_payload,
  output logic          out_valid,
  input  wire           out_ready,
  output payload_t      out_payload
);

  logic full;

  // take a new entry when empty or when the old one leaves this cycle
  assign in_ready  = ~full | out_ready;
  assign out_valid = full;

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  // payload only, loaded on push
  always_ff @(posedge axis_clk) begin
    if (in_valid && in_ready) begin
      out_payload <= in_payload;
    end
  end

endmodule

`default_nettype wire

//--- src/axil_slave_port.sv
// one request at a time, no B channel; awready/wready pulse marks the end of a write
`timescale 1ns/10ps
`default_nettype none
`include "aa_cfg.svh"

module axil_slave_port (
  input  wire                       axis_clk,
  input  wire                       axis_rst_n,
  // write address and write data
  input  wire                       s_awvalid,
  output logic                      s_awready,
  input  wire  [`AA_LS_ADDR_W-1:0]  s_awaddr,
  input  wire                       s_wvalid,
  output logic                      s_wready,
  input  wire  [`AA_DATA_W-1:0]     s_wdata,
  input  wire  [`AA_STRB_W-1:0]     s_wstrb,
  // read address and read data
  input  wire                       s_arvalid,
  output logic                      s_arready,
  input  wire  [`AA_LS_ADDR_W-1:0]  s_araddr,
  output logic                      s_rvalid,
  input  wire                       s_rready,
  output logic [`AA_DATA_W-1:0]     s_rdata,
  input  wire                       cc_aa_enable,
  // register file side
  output logic                      loc_wr_en,
  output logic [`AA_LS_ADDR_W-1:0]  loc_addr,
  output logic [`AA_DATA_W-1:0]     loc_wdata,
  output logic [`AA_STRB_W-1:0]     loc_wstrb,
  input  wire  [`AA_DATA_W-1:0]     loc_rdata,
  // push into the tx slot
  output logic                      fwd_valid,
  input  wire                       fwd_ready,
  output aa_axil_pkg::fwd_wr_t      fwd_payload
);
  import aa_axil_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_FWD,
    ST_READ,
    ST_RDONE
  } state_t;

  state_t                    state;
  logic                      wr_ack;
  logic                      wr_req;
  logic                      rd_req;
  region_t                   region_q;
  logic [`AA_LS_ADDR_W-1:0]  addr_q;
  logic [`AA_DATA_W-1:0]     data_q;
  logic [`AA_STRB_W-1:0]     strb_q;
  logic [`AA_DATA_W-1:0]     rdata_q;

  // nothing is accepted while the bridge is disabled
  assign wr_req = cc_aa_enable & s_awvalid & s_wvalid;
  assign rd_req = cc_aa_enable & s_arvalid;

  // ----------------------------------------
  // request FSM
  // ----------------------------------------
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      state  <= ST_IDLE;
      wr_ack <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          // writes win over a read in the same cycle
          if (wr_req) begin
            state <= ST_WRITE;
          end else if (rd_req) begin
            state <= ST_READ;
          end
        end
        ST_WRITE: begin
          // second cycle of a local write is the ack and register update
          if (wr_ack) begin
            wr_ack <= 1'b0;
            state  <= ST_IDLE;
          end else if (region_q == REGION_OUT) begin
            state <= ST_FWD;
          end else begin
            wr_ack <= 1'b1;
          end
        end
        ST_FWD: begin
          if (fwd_ready) begin
            state <= ST_IDLE;
          end
        end
        ST_READ:  state <= ST_RDONE;
        ST_RDONE: begin
          if (s_rready) begin
            state <= ST_IDLE;
          end
        end
        default:  state <= ST_IDLE;
      endcase
    end
  end

  // request latches, loaded only from idle
  always_ff @(posedge axis_clk) begin
    if (state == ST_IDLE && wr_req) begin
      addr_q   <= s_awaddr;
      data_q   <= s_wdata;
      strb_q   <= s_wstrb;
      region_q <= decode_region(s_awaddr[11:8]);
    end else if (state == ST_IDLE && rd_req) begin
      addr_q <= s_araddr;
    end
    // outside regions read back as zero from the register file
    if (state == ST_READ) begin
      rdata_q <= loc_rdata;
    end
  end

  // forwarded writes complete on the slot handshake
  assign s_awready = (state == ST_WRITE && wr_ack) || (state == ST_FWD && fwd_ready);
  assign s_wready  = s_awready;
  assign s_arready = (state == ST_READ);
  assign s_rvalid  = (state == ST_RDONE);
  assign s_rdata   = rdata_q;

  assign loc_wr_en = (state == ST_WRITE) && wr_ack;
  assign loc_addr  = addr_q;
  assign loc_wdata = data_q;
  assign loc_wstrb = strb_q;

  assign fwd_valid   = (state == ST_FWD);
  assign fwd_payload = '{addr: addr_q, data: data_q, strb: strb_q};

endmodule

`default_nettype wire

//--- src/stream_tx.sv
// sends each forwarded write as two beats with tuser 01; the slot payload stays put until popped
`timescale 1ns/10ps
`default_nettype none
`include "aa_cfg.svh"

module stream_tx (
  input  wire                     axis_clk,
  input  wire                     axis_rst_n,
  input  wire                     req_valid,
  output logic                    req_ready,
  input  wire aa_axil_pkg::fwd_wr_t req_payload,
  output logic [`AA_DATA_W-1:0]   tdata,
  output logic [`AA_STRB_W-1:0]   tstrb,
  output logic [`AA_TUSER_W-1:0]  tuser,
  output logic                    tvalid,
  input  wire                     tready
);
  import aa_axis_pkg::*;

  localparam int addr_pad_w = `AA_SS_ADDR_W - `AA_LS_ADDR_W;

  logic        busy;
  beat_phase_t phase;

  // busy starts a cycle after the slot shows valid
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      busy  <= 1'b0;
      phase <= PHASE_ADDR;
    end else if (!busy) begin
      busy  <= req_valid;
      phase <= PHASE_ADDR;
    end else if (tready) begin
      if (phase == PHASE_ADDR) begin
        phase <= PHASE_DATA;
      end else begin
        busy  <= 1'b0;
        phase <= PHASE_ADDR;
      end
    end
  end

  // pop only once the data beat is taken
  assign req_ready = busy & tready & (phase == PHASE_DATA);

  // ----------------------------------------
  // beat contents
  // ----------------------------------------
  assign tvalid = busy;
  assign tuser  = `AA_TUSER_AXIL_WR;
  assign tstrb  = req_payload.strb;
  // first beat is strobe over zero-extended address
  assign tdata  = (phase == PHASE_ADDR) ?
                  {req_payload.strb, {addr_pad_w{1'b0}}, req_payload.addr} :
                  req_payload.data;

endmodule

`default_nettype wire

//--- src/stream_rx.sv
// only tuser 01 beats are assembled; every other beat is taken and dropped
`timescale 1ns/10ps
`default_nettype none
`include "aa_cfg.svh"

module stream_rx (
  input  wire                      axis_clk,
  input  wire                      axis_rst_n,
  input  wire  [`AA_DATA_W-1:0]    tdata,
  input  wire  [`AA_STRB_W-1:0]    tstrb,
  input  wire  [`AA_TUSER_W-1:0]   tuser,
  input  wire                      tvalid,
  output logic                     tready,
  output logic                     wr_valid,
  input  wire                      wr_ready,
  output aa_axis_pkg::remote_wr_t  wr_payload
);
  import aa_axis_pkg::*;

  beat_phase_t              phase;
  logic                     armed;
  logic                     is_wr;
  logic                     take;
  logic [`AA_SS_ADDR_W-1:0] addr_q;
  logic [`AA_STRB_W-1:0]    strb_q;

  // data beat is held off while the rx slot is full
  assign tready = armed & ((phase == PHASE_ADDR) | wr_ready);
  assign take   = tvalid & tready;
  assign is_wr  = (tuser == `AA_TUSER_AXIL_WR);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      armed <= 1'b0;
      phase <= PHASE_ADDR;
    end else begin
      // keeps tready low through reset
      armed <= 1'b1;
      if (take && is_wr) begin
        phase <= (phase == PHASE_ADDR) ? PHASE_DATA : PHASE_ADDR;
      end
    end
  end

  // first beat is strobe in the top nibble, address below
  always_ff @(posedge axis_clk) begin
    if (take && is_wr && phase == PHASE_ADDR) begin
      {strb_q, addr_q} <= tdata;
    end
  end

  // the slot latches the word straight off the data beat
  assign wr_valid   = armed & tvalid & is_wr & (phase == PHASE_DATA);
  // data beat tstrb masks the bytes too
  assign wr_payload = '{addr: addr_q, data: tdata, strb: strb_q & tstrb};

endmodule

`default_nettype wire

//--- src/mbox_regs.sv
// 8-word mailbox plus enable/status; a local write always wins over a waiting remote write
`timescale 1ns/10ps
`default_nettype none
`include "aa_cfg.svh"

module mbox_regs (
  input  wire                       axis_clk,
  input  wire                       axis_rst_n,
  input  wire                       loc_wr_en,
  input  wire  [`AA_LS_ADDR_W-1:0]  loc_addr,
  input  wire  [`AA_DATA_W-1:0]     loc_wdata,
  input  wire  [`AA_STRB_W-1:0]     loc_wstrb,
  output logic [`AA_DATA_W-1:0]     loc_rdata,
  input  wire                       rem_valid,
  output logic                      rem_ready,
  input  wire aa_axis_pkg::remote_wr_t rem_payload,
  output logic                      mb_irq
);
  import aa_axil_pkg::*;

  logic [`AA_DATA_W-1:0]    mbox [`AA_MBOX_DEPTH];
  logic                     intr_enable;
  logic                     intr_status;
  logic                     rem_fire;
  logic                     wr_en;
  logic [11:0]              wr_addr;
  logic [`AA_DATA_W-1:0]    wr_data;
  logic [`AA_STRB_W-1:0]    wr_strb;
  logic [`AA_MBOX_IDX_W-1:0] wr_idx;
  region_t                  wr_region;
  region_t                  rd_region;
  logic                     status_clr;
  logic                     status_set;

  assign rem_ready = ~loc_wr_en;
  assign rem_fire  = rem_valid & rem_ready;
  assign wr_en     = loc_wr_en | rem_fire;

  // ----------------------------------------
  // shared write port
  // ----------------------------------------
  always_comb begin
    if (loc_wr_en) begin
      wr_addr = loc_addr[11:0];
      wr_data = loc_wdata;
      wr_strb = loc_wstrb;
    end else begin
      wr_addr = rem_payload.addr[11:0];
      wr_data = rem_payload.data;
      wr_strb = rem_payload.strb;
    end
  end

  assign wr_region = decode_region(wr_addr[11:8]);
  assign wr_idx    = wr_addr[`AA_MBOX_IDX_W+1:2];

  // byte-merged mailbox update
  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      for (int i = 0; i < `AA_MBOX_DEPTH; i++) begin
        mbox[i] <= '0;
      end
    end else if (wr_en && wr_region == REGION_MBOX) begin
      for (int b = 0; b < `AA_STRB_W; b++) begin
        if (wr_strb[b]) begin
          mbox[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // status: cleared by local W1C at offset 4, set by any remote mailbox write
  assign status_clr = loc_wr_en & (wr_region == REGION_REG) & wr_addr[2] &
                      wr_strb[0] & wr_data[0];
  assign status_set = rem_fire & (wr_region == REGION_MBOX) & (|wr_strb);

  always_ff @(posedge axis_clk or negedge axis_rst_n) begin
    if (!axis_rst_n) begin
      intr_enable <= 1'b0;
      intr_status <= 1'b0;
    end else begin
      // enable at offset 0, writable from either side
      if (wr_en && wr_region == REGION_REG && !wr_addr[2] && wr_strb[0]) begin
        intr_enable <= wr_data[0];
      end
      if (status_clr) begin
        intr_status <= 1'b0;
      end else if (status_set) begin
        intr_status <= 1'b1;
      end
    end
  end

  assign mb_irq = intr_status & intr_enable;

  // local read, zero outside the bridge
  assign rd_region = decode_region(loc_addr[11:8]);

  always_comb begin
    case (rd_region)
      REGION_REG:  loc_rdata = {{(`AA_DATA_W-1){1'b0}}, loc_addr[2] ? intr_status : intr_enable};
      REGION_MBOX: loc_rdata = mbox[loc_addr[`AA_MBOX_IDX_W+1:2]];
      default:     loc_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/axil_axis_bridge.sv
// single axis_clk domain; tkeep/tlast are not driven or checked, remote reads are not supported
`timescale 1ns/10ps
`default_nettype none
`include "aa_cfg.svh"

module axil_axis_bridge (
  input  wire                       axis_clk,
  input  wire                       axis_rst_n,
  // AXI-Lite slave
  input  wire                       s_awvalid,
  output logic                      s_awready,
  input  wire  [`AA_LS_ADDR_W-1:0]  s_awaddr,
  input  wire                       s_wvalid,
  output logic                      s_wready,
  input  wire  [`AA_DATA_W-1:0]     s_wdata,
  input  wire  [`AA_STRB_W-1:0]     s_wstrb,
  input  wire                       s_arvalid,
  output logic                      s_arready,
  input  wire  [`AA_LS_ADDR_W-1:0]  s_araddr,
  output logic                      s_rvalid,
  input  wire                       s_rready,
  output logic [`AA_DATA_W-1:0]     s_rdata,
  input  wire                       cc_aa_enable,
  // stream master
  output logic [`AA_DATA_W-1:0]     aa_as_tdata,
  output logic [`AA_STRB_W-1:0]     aa_as_tstrb,
  output logic [`AA_TUSER_W-1:0]    aa_as_tuser,
  output logic                      aa_as_tvalid,
  input  wire                       as_aa_tready,
  // stream slave
  input  wire  [`AA_DATA_W-1:0]     as_aa_tdata,
  input  wire  [`AA_STRB_W-1:0]     as_aa_tstrb,
  input  wire  [`AA_TUSER_W-1:0]    as_aa_tuser,
  input  wire                       as_aa_tvalid,
  output logic                      aa_as_tready,
  output logic                      mb_irq
);
  import aa_axil_pkg::*;
  import aa_axis_pkg::*;

  // local register path
  logic                      loc_wr_en;
  logic [`AA_LS_ADDR_W-1:0]  loc_addr;
  logic [`AA_DATA_W-1:0]     loc_wdata;
  logic [`AA_STRB_W-1:0]     loc_wstrb;
  logic [`AA_DATA_W-1:0]     loc_rdata;
  // tx path, port to slot to packer
  logic                      fwd_valid;
  logic                      fwd_ready;
  fwd_wr_t                   fwd_payload;
  logic                      txq_valid;
  logic                      txq_ready;
  fwd_wr_t                   txq_payload;
  // rx path, assembler to slot to registers
  logic                      rxw_valid;
  logic                      rxw_ready;
  remote_wr_t                rxw_payload;
  logic                      rem_valid;
  logic                      rem_ready;
  remote_wr_t                rem_payload;

  axil_slave_port u_slave (.*);

  hold_slot #(.payload_t(fwd_wr_t)) u_tx_slot (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .in_valid    (fwd_valid),
    .in_ready    (fwd_ready),
    .in_payload  (fwd_payload),
    .out_valid   (txq_valid),
    .out_ready   (txq_ready),
    .out_payload (txq_payload)
  );

  stream_tx u_tx (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .req_valid   (txq_valid),
    .req_ready   (txq_ready),
    .req_payload (txq_payload),
    .tdata       (aa_as_tdata),
    .tstrb       (aa_as_tstrb),
    .tuser       (aa_as_tuser),
    .tvalid      (aa_as_tvalid),
    .tready      (as_aa_tready)
  );

  stream_rx u_rx (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .tdata       (as_aa_tdata),
    .tstrb       (as_aa_tstrb),
    .tuser       (as_aa_tuser),
    .tvalid      (as_aa_tvalid),
    .tready      (aa_as_tready),
    .wr_valid    (rxw_valid),
    .wr_ready    (rxw_ready),
    .wr_payload  (rxw_payload)
  );

  hold_slot #(.payload_t(remote_wr_t)) u_rx_slot (
    .axis_clk    (axis_clk),
    .axis_rst_n  (axis_rst_n),
    .in_valid    (rxw_valid),
    .in_ready    (rxw_ready),
    .in_payload  (rxw_payload),
    .out_valid   (rem_valid),
    .out_ready   (rem_ready),
    .out_payload (rem_payload)
  );

  mbox_regs u_regs (.*);

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
// free-running 100 ns clock; reset held low for the first 10 rising edges, then released
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic axis_clk,
  output logic axis_rst_n
);

  initial begin
    axis_clk = 1'b0;
    forever #50 axis_clk = ~axis_clk;
  end

  // release on a rising edge so the DUT sees a clean edge
  initial begin
    axis_rst_n = 1'b0;
    repeat (10) @(posedge axis_clk);
    axis_rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/bridge_properties.sv
// bound into the bridge top; checks only handshake stability, not data content of the registers
`timescale 1ns/10ps
`default_nettype none
`include "aa_cfg.svh"

module bridge_properties (
  input wire                     axis_clk,
  input wire                     axis_rst_n,
  input wire                     s_awready,
  input wire                     s_rvalid,
  input wire                     s_rready,
  input wire [`AA_DATA_W-1:0]    s_rdata,
  input wire [`AA_DATA_W-1:0]    aa_as_tdata,
  input wire [`AA_STRB_W-1:0]    aa_as_tstrb,
  input wire [`AA_TUSER_W-1:0]   aa_as_tuser,
  input wire                     aa_as_tvalid,
  input wire                     as_aa_tready
);

  // ----------------------------------------
  // stream master
  // ----------------------------------------
  // a stalled beat keeps its contents
  a_beat_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    aa_as_tvalid && !as_aa_tready |=> aa_as_tvalid && $stable(aa_as_tdata) &&
    $stable(aa_as_tstrb) && $stable(aa_as_tuser))
    else $error("stream beat changed under back-pressure");

  // ----------------------------------------
  // AXI-Lite slave
  // ----------------------------------------
  // write completion is a single-cycle pulse
  a_aw_pulse: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_awready |=> !s_awready)
    else $error("awready held longer than one cycle");

  a_r_stable: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata))
    else $error("read data dropped or changed before rready");

endmodule

`default_nettype wire

//--- sim/tb_axil_axis_bridge.sv
// single-clock testbench; all stimulus on rising edges, every wait bounded by a cycle timeout
`timescale 1ns/10ps
`default_nettype none

module tb_axil_axis_bridge;

  localparam int timeout = 200;

  logic        axis_clk;
  logic        axis_rst_n;
  logic        s_awvalid = 1'b0;
  logic [14:0] s_awaddr = '0;
  logic        s_wvalid = 1'b0;
  logic [31:0] s_wdata = '0;
  logic [3:0]  s_wstrb = '0;
  logic        s_arvalid = 1'b0;
  logic [14:0] s_araddr = '0;
  logic        s_rready = 1'b0;
  logic        cc_aa_enable = 1'b0;
  logic        as_aa_tready = 1'b0;
  logic [31:0] as_aa_tdata = '0;
  logic [3:0]  as_aa_tstrb = '0;
  logic [1:0]  as_aa_tuser = '0;
  logic        as_aa_tvalid = 1'b0;
  wire         s_awready;
  wire         s_wready;
  wire         s_arready;
  wire         s_rvalid;
  wire         aa_as_tvalid;
  wire         aa_as_tready;
  wire         mb_irq;
  wire  [31:0] s_rdata;
  wire  [31:0] aa_as_tdata;
  wire  [3:0]  aa_as_tstrb;
  wire  [1:0]  aa_as_tuser;

  // testbench state
  logic [31:0] lcg_state = 32'd43311;
  logic [31:0] mbox_model [8];
  logic [31:0] beat_data [$];
  logic [3:0]  beat_strb [$];
  logic [1:0]  beat_user [$];
  logic        stall_en = 1'b0;
  logic        tready_hold = 1'b1;

  tb_clk_gen u_clk (.axis_clk(axis_clk), .axis_rst_n(axis_rst_n));

  axil_axis_bridge dut (.*);

  bind axil_axis_bridge bridge_properties u_props (
    .axis_clk(axis_clk), .axis_rst_n(axis_rst_n), .s_awready(s_awready),
    .s_rvalid(s_rvalid), .s_rready(s_rready), .s_rdata(s_rdata),
    .aa_as_tdata(aa_as_tdata), .aa_as_tstrb(aa_as_tstrb), .aa_as_tuser(aa_as_tuser),
    .aa_as_tvalid(aa_as_tvalid), .as_aa_tready(as_aa_tready)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // byte lanes with strobe set take the new value
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old_w;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) r[8*b +: 8] = new_w[8*b +: 8];
    end
    return r;
  endfunction

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Test failed");
      $fatal(1, "run stopped");
    end
  endtask

  // tready follows random stalls or a held level
  always @(posedge axis_clk) begin
    as_aa_tready <= stall_en ? ((lcg_next() % 3) != 0) : tready_hold;
  end

  // stream master monitor
  always @(posedge axis_clk) begin
    if (axis_rst_n && aa_as_tvalid && as_aa_tready) begin
      beat_data.push_back(aa_as_tdata);
      beat_strb.push_back(aa_as_tstrb);
      beat_user.push_back(aa_as_tuser);
    end
  end

  // ----------------------------------------
  // AXI-Lite and stream drivers
  // ----------------------------------------
  task automatic start_write(input logic [14:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    @(posedge axis_clk);
    s_awvalid <= 1'b1;
    s_awaddr  <= addr;
    s_wvalid  <= 1'b1;
    s_wdata   <= data;
    s_wstrb   <= strb;
  endtask

  task automatic finish_write();
    int n;
    n = 0;
    @(posedge axis_clk);
    while (!s_awready) begin
      if (n == timeout) fail_now("write handshake never completed");
      n++;
      @(posedge axis_clk);
    end
    check_value("s_wready", 32'(s_wready), 1);
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
  endtask

  task automatic axil_write(input logic [14:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    start_write(addr, data, strb);
    finish_write();
  endtask

  task automatic axil_read(input logic [14:0] addr, output logic [31:0] data);
    int n;
    n = 0;
    @(posedge axis_clk);
    s_arvalid <= 1'b1;
    s_araddr  <= addr;
    @(posedge axis_clk);
    while (!s_arready) begin
      if (n == timeout) fail_now("read address never accepted");
      n++;
      @(posedge axis_clk);
    end
    s_arvalid <= 1'b0;
    n = 0;
    @(posedge axis_clk);
    while (!s_rvalid) begin
      if (n == timeout) fail_now("read data never returned");
      n++;
      @(posedge axis_clk);
    end
    // rready comes a cycle late so read data has to wait once
    s_rready <= 1'b1;
    @(posedge axis_clk);
    data = s_rdata;
    s_rready <= 1'b0;
  endtask

  task automatic send_beat(input logic [31:0] data, input logic [3:0] strb,
                           input logic [1:0] user);
    int n;
    n = 0;
    @(posedge axis_clk);
    as_aa_tvalid <= 1'b1;
    as_aa_tdata  <= data;
    as_aa_tstrb  <= strb;
    as_aa_tuser  <= user;
    @(posedge axis_clk);
    while (!aa_as_tready) begin
      if (n == timeout) fail_now("stream slave never took a beat");
      n++;
      @(posedge axis_clk);
    end
    as_aa_tvalid <= 1'b0;
  endtask

  // queue is looked at on the falling edge, after the monitor has pushed
  task automatic wait_beats(input int count);
    int n;
    n = 0;
    @(negedge axis_clk);
    while (beat_data.size() < count) begin
      if (n == timeout) fail_now("expected stream beats did not arrive");
      n++;
      @(negedge axis_clk);
    end
  endtask

  // a forwarded write shows up as strobe over address, then the data word
  task automatic check_fwd_beats(input int first, input logic [14:0] addr,
                                 input logic [31:0] data, input logic [3:0] strb);
    check_value("aa_as_tdata addr beat", beat_data[first], {strb, 13'h0, addr});
    check_value("aa_as_tstrb addr beat", 32'(beat_strb[first]), 32'(strb));
    check_value("aa_as_tuser addr beat", 32'(beat_user[first]), 32'(2'b01));
    check_value("aa_as_tdata data beat", beat_data[first+1], data);
    check_value("aa_as_tstrb data beat", 32'(beat_strb[first+1]), 32'(strb));
    check_value("aa_as_tuser data beat", 32'(beat_user[first+1]), 32'(2'b01));
  endtask

  initial begin
    #10_000_000;
    fail_now("simulation ran past its overall time limit");
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] d;
    logic [31:0] rnd;
    logic [3:0]  s;
    logic [2:0]  idx;
    int          n;

    for (int i = 0; i < 8; i++) mbox_model[i] = '0;
    // outputs quiet during reset
    repeat (5) @(posedge axis_clk);
    check_value("s_awready", 32'(s_awready), 0);
    check_value("s_wready", 32'(s_wready), 0);
    check_value("s_arready", 32'(s_arready), 0);
    check_value("s_rvalid", 32'(s_rvalid), 0);
    check_value("aa_as_tvalid", 32'(aa_as_tvalid), 0);
    check_value("aa_as_tready", 32'(aa_as_tready), 0);
    check_value("mb_irq", 32'(mb_irq), 0);
    n = 0;
    while (!axis_rst_n) begin
      if (n == timeout) fail_now("reset was never released");
      n++;
      @(posedge axis_clk);
    end
    cc_aa_enable <= 1'b1;

    // enable and status registers
    axil_read(15'h104, rd);
    check_value("status", rd, 0);
    axil_write(15'h100, 32'h1, 4'h1);
    axil_read(15'h100, rd);
    check_value("enable", rd, 1);

    // local mailbox writes with byte merging
    for (int k = 0; k < 6; k++) begin
      rnd = lcg_next();
      idx = rnd[31:29];
      d   = lcg_next();
      rnd = lcg_next();
      s   = rnd[31:28];
      axil_write({10'h0, idx, 2'b00}, d, s);
      mbox_model[idx] = merge_bytes(mbox_model[idx], d, s);
      axil_read({10'h0, idx, 2'b00}, rd);
      check_value("mailbox word", rd, mbox_model[idx]);
    end
    check_value("mb_irq", 32'(mb_irq), 0);

    // forwarded write under random stalls
    stall_en <= 1'b1;
    d   = lcg_next();
    rnd = lcg_next();
    s   = rnd[31:28];
    axil_write(15'h0204, d, s);
    wait_beats(2);
    check_fwd_beats(0, 15'h0204, d, s);
    stall_en <= 1'b0;

    // remote mailbox write raises the interrupt
    d   = lcg_next();
    rnd = lcg_next();
    s   = rnd[31:28] | 4'h1;
    send_beat({s, 28'h14}, 4'hF, 2'b01);
    send_beat(d, 4'hF, 2'b01);
    mbox_model[5] = merge_bytes(mbox_model[5], d, s);
    n = 0;
    while (!mb_irq) begin
      if (n == timeout) fail_now("mb_irq never rose after a remote mailbox write");
      n++;
      @(posedge axis_clk);
    end
    axil_read(15'h014, rd);
    check_value("remote mailbox word", rd, mbox_model[5]);
    axil_write(15'h104, 32'h1, 4'h1);
    @(posedge axis_clk);
    check_value("mb_irq after clear", 32'(mb_irq), 0);

    // back-pressure holds off a second forwarded write
    tready_hold <= 1'b0;
    beat_data.delete();
    beat_strb.delete();
    beat_user.delete();
    axil_write(15'h0300, 32'hA5A5_0001, 4'hF);
    start_write(15'h0308, 32'h5A5A_0002, 4'h3);
    for (int c = 0; c < 40; c++) begin
      @(posedge axis_clk);
      if (s_awready) fail_now("second forwarded write completed under back-pressure");
    end
    tready_hold <= 1'b1;
    finish_write();
    wait_beats(4);
    check_fwd_beats(0, 15'h0300, 32'hA5A5_0001, 4'hF);
    check_fwd_beats(2, 15'h0308, 32'h5A5A_0002, 4'h3);

    // other tuser codes are dropped
    send_beat({4'hF, 28'h14}, 4'hF, 2'b10);
    send_beat(32'hDEAD_BEEF, 4'hF, 2'b10);
    repeat (3) @(posedge axis_clk);
    axil_read(15'h014, rd);
    check_value("mailbox after tuser 10", rd, mbox_model[5]);
    check_value("mb_irq after tuser 10", 32'(mb_irq), 0);

    // disabled bridge takes no requests
    cc_aa_enable <= 1'b0;
    start_write(15'h000, 32'h1234_5678, 4'hF);
    s_arvalid <= 1'b1;
    s_araddr  <= 15'h000;
    for (int c = 0; c < 40; c++) begin
      @(posedge axis_clk);
      if (s_awready || s_arready) fail_now("handshake occurred while cc_aa_enable was low");
    end
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    s_arvalid <= 1'b0;
    repeat (2) @(posedge axis_clk);

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/aa_axil_pkg.sv
src/aa_axis_pkg.sv
src/hold_slot.sv
src/axil_slave_port.sv
src/stream_tx.sv
src/stream_rx.sv
src/mbox_regs.sv
src/axil_axis_bridge.sv
sim/tb_clk_gen.sv
sim/bridge_properties.sv
sim/tb_axil_axis_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the bridge testbench with Verilator and runs it
cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "cannot enter project root"
  exit 1
fi

verilator --binary --timing --assert -f verilog.f --top-module tb_axil_axis_bridge
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_axil_axis_bridge 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Test passed$"; then
  exit 0
fi
echo "pass message not found"
exit 1
